// ==== design/riscv_mem_pkg.sv ====
//********************
// Shared widths, memory sizing, funct3 size codes and the memory word
// union for the MEM/WB end of the RV32I pipeline.
// Import inside module bodies, use scoped names in port lists.
//********************

package riscv_mem_pkg;

  // Datapath
  localparam int XLEN      = 32;       // Integer register width
  localparam int NUM_BYTES = XLEN / 8; // Byte lanes per word

  // Data memory geometry
  localparam int DMEM_DEPTH = 1024;               // Words
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH); // Word address from alu_out[11:2]

  // Register file index
  localparam int REG_AW = 5;

  // Load/store funct3 size codes
  // Bit 2 flags an unsigned load
  localparam logic [2:0] F3_B  = 3'd0; // Signed byte on load
  localparam logic [2:0] F3_H  = 3'd1; // Signed halfword on load
  localparam logic [2:0] F3_W  = 3'd2; // Full word
  localparam logic [2:0] F3_BU = 3'd4; // Zero-extended byte
  localparam logic [2:0] F3_HU = 3'd5; // Zero-extended halfword

  // One memory word seen three ways
  // bytes[0] and halves[0] are the low-order lanes (little endian)
  typedef union packed {
    logic [XLEN-1:0]                 word;   // Whole word
    logic [NUM_BYTES-1:0][7:0]       bytes;  // Indexed by addr[1:0]
    logic [NUM_BYTES/2-1:0][15:0]    halves; // Indexed by addr[1]
  } mem_word_u;

endpackage

// ==== design/store_align.sv ====
//********************
// Store lane alignment. Replicates the store data across the byte lanes
// and builds the byte enables from the access size and address offset.
// Purely combinational, sits in front of the data memory.
//********************

`timescale 1ns/1ps

module store_align (
  input  logic [1:0]                          i_offset,     // alu_out[1:0]
  input  logic [2:0]                          i_funct3,     // Store size
  input  logic [riscv_mem_pkg::XLEN-1:0]      i_store_data, // rs2 value
  output logic [riscv_mem_pkg::NUM_BYTES-1:0] o_byte_en,    // Lane write enables
  output logic [riscv_mem_pkg::XLEN-1:0]      o_wdata       // Lane-replicated data
);

  import riscv_mem_pkg::*;

  mem_word_u lane_data; // Write data built lane by lane

  always_comb begin
    lane_data.word = i_store_data; // Word store passes through
    o_byte_en      = '0;

    case (i_funct3)
      F3_B: begin
        // Low byte copied into every lane
        lane_data.bytes = {NUM_BYTES{i_store_data[7:0]}};
        o_byte_en       = NUM_BYTES'(1) << i_offset;
      end
      F3_H: begin
        lane_data.halves = {2{i_store_data[15:0]}}; // Low half into both halves
        // Offset bit 0 ignored, no misalign trap here
        o_byte_en = i_offset[1] ? 4'b1100 : 4'b0011;
      end
      F3_W: begin
        o_byte_en = '1; // All lanes, offset ignored
      end
      default: begin
        o_byte_en = '0; // BU/HU and reserved codes are no store sizes
      end
    endcase
  end

  assign o_wdata = lane_data.word;

endmodule

// ==== design/dmem.sv ====
//********************
// Byte-writable data memory, one word per address.
// Write-first: a cycle that writes returns the merged word on the
// registered read port. Read latency is one clock, read always happens.
//********************

`timescale 1ns/1ps

module dmem (
  input  logic                                i_clk,
  input  logic [riscv_mem_pkg::DMEM_AW-1:0]   i_addr,    // Word address
  input  logic                                i_we,      // Store this cycle
  input  logic [riscv_mem_pkg::NUM_BYTES-1:0] i_byte_en, // Lanes to write
  input  logic [riscv_mem_pkg::XLEN-1:0]      i_wdata,   // Aligned lane data
  output logic [riscv_mem_pkg::XLEN-1:0]      o_rdata    // Registered read word
);

  import riscv_mem_pkg::*;

  logic [XLEN-1:0] mem [DMEM_DEPTH]; // Storage, survives reset

  logic [XLEN-1:0] cur_word;    // Current contents at i_addr
  logic [XLEN-1:0] merged_word; // Contents after this cycle's store

  // Memory comes up cleared
  initial begin
    for (int w = 0; w < DMEM_DEPTH; w++) begin
      mem[w] = '0;
    end
  end

  assign cur_word = mem[i_addr];

  // Overlay enabled lanes on the old word
  always_comb begin
    merged_word = cur_word;
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (i_byte_en[b]) begin
        merged_word[8*b +: 8] = i_wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= merged_word;
      o_rdata     <= merged_word; // Write-first view
    end else begin
      o_rdata <= cur_word;
    end
  end

endmodule

// ==== design/load_extend.sv ====
//********************
// Load data extraction. Picks the byte, halfword or word addressed by
// the offset out of a read word and sign- or zero-extends it.
// Combinational, fed by the registered memory read.
//********************

`timescale 1ns/1ps

module load_extend (
  input  logic [riscv_mem_pkg::XLEN-1:0] i_rdata,    // Full memory word
  input  logic [1:0]                     i_offset,   // Byte offset in word
  input  logic [2:0]                     i_funct3,   // Load size and sign
  output logic [riscv_mem_pkg::XLEN-1:0] o_load_data // Value for rd
);

  import riscv_mem_pkg::*;

  mem_word_u  rd_word;  // Read word, byte/half views
  logic [7:0]  sel_byte; // Byte at offset
  logic [15:0] sel_half; // Half at offset bit 1
  logic        fill_b;   // Extension bit, byte loads
  logic        fill_h;   // Extension bit, half loads

  assign rd_word.word = i_rdata;
  assign sel_byte     = rd_word.bytes[i_offset];
  assign sel_half     = rd_word.halves[i_offset[1]]; // Bit 0 ignored

  // funct3[2] set means zero-extend
  assign fill_b = ~i_funct3[2] & sel_byte[7];
  assign fill_h = ~i_funct3[2] & sel_half[15];

  always_comb begin
    case (i_funct3)
      F3_B, F3_BU: begin
        o_load_data = {{(XLEN-8){fill_b}}, sel_byte};
      end
      F3_H, F3_HU: begin
        o_load_data = {{(XLEN-16){fill_h}}, sel_half};
      end
      F3_W: begin
        o_load_data = rd_word.word;
      end
      default: begin
        // Reserved size codes, hand back the raw word
        o_load_data = rd_word.word;
      end
    endcase
  end

endmodule

// ==== design/wback_reg.sv ====
//********************
// MEM/WB pipeline register plus the write-back select.
// Size and offset are held next to the memory's registered read so the
// load value is extracted after the edge. Latency one cycle.
//********************

`timescale 1ns/1ps

module wback_reg (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_pc,
  input  logic                             i_reg_write,
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_rd,
  input  logic                             i_mem_to_reg, // Result from memory
  input  logic [2:0]                       i_funct3,
  input  logic [1:0]                       i_offset,     // alu_out[1:0]
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_alu_out,
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_rdata,      // Already registered in dmem
  output logic [riscv_mem_pkg::XLEN-1:0]   o_wb_pc,
  output logic                             o_wb_reg_write,
  output logic [riscv_mem_pkg::REG_AW-1:0] o_wb_rd,
  output logic [riscv_mem_pkg::XLEN-1:0]   o_wb_data
);

  import riscv_mem_pkg::*;

  logic            mem_to_reg_q; // Select for write-back mux
  logic [2:0]      funct3_q;     // Load size, aligned with i_rdata
  logic [1:0]      offset_q;     // Byte offset, aligned with i_rdata
  logic [XLEN-1:0] alu_q;        // ALU result
  logic [XLEN-1:0] load_data;    // Extended load value

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_pc        <= '0;
      o_wb_reg_write <= 1'b0;
      o_wb_rd        <= '0;
      mem_to_reg_q   <= 1'b0;
      funct3_q       <= '0;
      offset_q       <= '0;
      alu_q          <= '0;
    end else begin
      o_wb_pc        <= i_pc;
      o_wb_reg_write <= i_reg_write;
      o_wb_rd        <= i_rd;
      mem_to_reg_q   <= i_mem_to_reg;
      funct3_q       <= i_funct3;
      offset_q       <= i_offset;
      alu_q          <= i_alu_out;
    end
  end

  load_extend u_load_extend (
    .i_rdata     (i_rdata),
    .i_offset    (offset_q),
    .i_funct3    (funct3_q),
    .o_load_data (load_data)
  );

  // Memory or ALU, zero after reset through alu_q
  assign o_wb_data = mem_to_reg_q ? load_data : alu_q;

endmodule

// ==== design/regfile.sv ====
//********************
// RV32I integer register file, 32 x 32, x0 hard-wired to zero.
// One write port from write-back, two combinational read ports for
// decode that bypass a write landing in the same cycle.
//********************

`timescale 1ns/1ps

module regfile (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  logic                             i_we,
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_waddr,
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_wdata,
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_raddr1, // rs1
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_raddr2, // rs2
  output logic [riscv_mem_pkg::XLEN-1:0]   o_rdata1,
  output logic [riscv_mem_pkg::XLEN-1:0]   o_rdata2
);

  import riscv_mem_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW]; // regs[0] never written
  logic            wr_en;            // Write to a real register

  assign wr_en = i_we && (i_waddr != '0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int r = 0; r < 2**REG_AW; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Priority is x0 then the pending write then the stored value
  function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
    if (addr == '0) return '0;
    if (wr_en && (addr == i_waddr)) return i_wdata;
    return regs[addr];
  endfunction

  always_comb begin
    o_rdata1 = read_port(i_raddr1);
  end

  always_comb begin
    o_rdata2 = read_port(i_raddr2);
  end

endmodule

// ==== design/mem_wb_stage.sv ====
//********************
// MEM and WB stages of the RV32I pipeline: store alignment, data memory,
// MEM/WB register with load extension, and the register file.
// One instruction accepted per cycle, no stalls.
//********************

`timescale 1ns/1ps

module mem_wb_stage (
  input  logic                             i_clk,
  input  logic                             i_reset,

  // MEM stage instruction
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_pc,
  input  logic                             i_reg_write,
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_rd,
  input  logic                             i_mem_read,
  input  logic                             i_mem_write,
  input  logic [2:0]                       i_funct3,
  input  logic                             i_mem_to_reg,
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_alu_out,    // Also the load/store address
  input  logic [riscv_mem_pkg::XLEN-1:0]   i_store_data,

  // Decode read indices
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_rs1_addr,
  input  logic [riscv_mem_pkg::REG_AW-1:0] i_rs2_addr,

  // Write-back
  output logic [riscv_mem_pkg::XLEN-1:0]   o_wb_pc,
  output logic                             o_wb_reg_write,
  output logic [riscv_mem_pkg::REG_AW-1:0] o_wb_rd,
  output logic [riscv_mem_pkg::XLEN-1:0]   o_wb_data,

  // Register read data to decode
  output logic [riscv_mem_pkg::XLEN-1:0]   o_rs1_data,
  output logic [riscv_mem_pkg::XLEN-1:0]   o_rs2_data
);

  import riscv_mem_pkg::*;

  logic [DMEM_AW-1:0]   word_addr; // alu_out[11:2] with upper bits wrapping
  logic [1:0]           byte_off;  // alu_out[1:0]
  logic [NUM_BYTES-1:0] byte_en;
  logic [XLEN-1:0]      lane_wdata;
  logic [XLEN-1:0]      mem_rdata; // Registered read word

  assign word_addr = i_alu_out[DMEM_AW+1:2];
  assign byte_off  = i_alu_out[1:0];

  store_align u_store_align (
    .i_offset     (byte_off),
    .i_funct3     (i_funct3),
    .i_store_data (i_store_data),
    .o_byte_en    (byte_en),
    .o_wdata      (lane_wdata)
  );

  dmem u_dmem (
    .i_clk     (i_clk),
    .i_addr    (word_addr),
    .i_we      (i_mem_write),
    .i_byte_en (byte_en),
    .i_wdata   (lane_wdata),
    .o_rdata   (mem_rdata)
  );

  wback_reg u_wback_reg (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_pc           (i_pc),
    .i_reg_write    (i_reg_write),
    .i_rd           (i_rd),
    .i_mem_to_reg   (i_mem_to_reg),
    .i_funct3       (i_funct3),
    .i_offset       (byte_off),
    .i_alu_out      (i_alu_out),
    .i_rdata        (mem_rdata),
    .o_wb_pc        (o_wb_pc),
    .o_wb_reg_write (o_wb_reg_write),
    .o_wb_rd        (o_wb_rd),
    .o_wb_data      (o_wb_data)
  );

  // Write-back feeds the write port directly
  regfile u_regfile (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_we     (o_wb_reg_write),
    .i_waddr  (o_wb_rd),
    .i_wdata  (o_wb_data),
    .i_raddr1 (i_rs1_addr),
    .i_raddr2 (i_rs2_addr),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

// ==== sim/tb_clock.sv ====
//********************
// Testbench clock and reset source.
// 4 ns clock, synchronous active-high reset held for 8 rising edges.
//********************

`timescale 1ns/1ps

module tb_clock (
  output logic o_clk,
  output logic o_reset
);

  localparam int HALF_PERIOD_NS = 2; // 4 ns period
  localparam int RESET_CYCLES   = 8;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD_NS o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0; // Released away from the rising edge
  end

endmodule

// ==== sim/tb_mem_wb_stage.sv ====
//********************
// Directed testbench for the MEM/WB stage. One instruction per cycle,
// driven on the falling edge, write-back and register reads checked
// against a byte-array memory model and a register model.
//********************

`timescale 1ns/1ps

module tb_mem_wb_stage;

  import riscv_mem_pkg::*;

  localparam int              RESET_WAIT_CYCLES = 50;    // Bound on reset release
  localparam int              WATCHDOG_CYCLES   = 20000; // Bound on the whole run
  localparam int              RAND_OPS          = 100;
  localparam logic [XLEN-1:0] RAND_BASE         = 32'h0000_0400; // 16 words from here

  logic              clk;
  logic              rst;
  logic [XLEN-1:0]   pc;
  logic              reg_write;
  logic [REG_AW-1:0] rd;
  logic              mem_read;
  logic              mem_write;
  logic [2:0]        funct3;
  logic              mem_to_reg;
  logic [XLEN-1:0]   alu_out;
  logic [XLEN-1:0]   store_data;
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  logic [XLEN-1:0]   wb_pc;
  logic              wb_reg_write;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_data;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;

  logic [7:0]        ref_mem [4*DMEM_DEPTH]; // Byte model indexed by alu_out[11:0]
  logic [XLEN-1:0]   reg_model [32];         // Register model with x0 never written
  integer            seed;
  logic [XLEN-1:0]   pc_ctr;
  logic [REG_AW-1:0] last_rd;   // Most recent real write target
  logic [REG_AW-1:0] probe_idx; // Sweeps rs2 over all registers
  string             cur_test;
  int                test_errs;
  int                total_errs;
  int                tests_run;
  int                tests_failed;
  logic              reset_seen;

  tb_clock u_tb_clock (
    .o_clk   (clk),
    .o_reset (rst)
  );

  mem_wb_stage u_mem_wb_stage (
    .i_clk (clk), .i_reset (rst), .i_pc (pc), .i_reg_write (reg_write), .i_rd (rd),
    .i_mem_read (mem_read), .i_mem_write (mem_write), .i_funct3 (funct3),
    .i_mem_to_reg (mem_to_reg), .i_alu_out (alu_out), .i_store_data (store_data),
    .i_rs1_addr (rs1_addr), .i_rs2_addr (rs2_addr), .o_wb_pc (wb_pc),
    .o_wb_reg_write (wb_reg_write), .o_wb_rd (wb_rd), .o_wb_data (wb_data),
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data)
  );

  function automatic int unsigned rand_below(input int unsigned limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  // Load value from the byte model with sign by funct3 bit 2
  function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] addr,
                                               input logic [2:0] f3);
    logic [DMEM_AW+1:0] a;
    logic [7:0]         b;
    logic [15:0]        h;
    a = addr[DMEM_AW+1:0];
    b = ref_mem[a];
    h = {ref_mem[{a[DMEM_AW+1:1], 1'b1}], ref_mem[{a[DMEM_AW+1:1], 1'b0}]};
    case (f3)
      F3_B:    return {{24{b[7]}}, b};
      F3_BU:   return {24'h0, b};
      F3_H:    return {{16{h[15]}}, h};
      F3_HU:   return {16'h0, h};
      default: return {ref_mem[{a[DMEM_AW+1:2], 2'd3}], ref_mem[{a[DMEM_AW+1:2], 2'd2}],
                       ref_mem[{a[DMEM_AW+1:2], 2'd1}], ref_mem[{a[DMEM_AW+1:2], 2'd0}]};
    endcase
  endfunction

  task automatic ref_store(input logic [XLEN-1:0] addr, input logic [2:0] f3,
                           input logic [XLEN-1:0] data);
    logic [DMEM_AW+1:0] a;
    a = addr[DMEM_AW+1:0];
    case (f3)
      F3_B: ref_mem[a] = data[7:0];
      F3_H: begin
        ref_mem[{a[DMEM_AW+1:1], 1'b0}] = data[7:0];  // Bit 0 of address dropped
        ref_mem[{a[DMEM_AW+1:1], 1'b1}] = data[15:8];
      end
      F3_W: begin
        for (int i = 0; i < 4; i++) begin
          ref_mem[{a[DMEM_AW+1:2], 2'(i)}] = data[8*i +: 8];
        end
      end
      default: ; // Not a store size
    endcase
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] exp_val,
                             input logic [XLEN-1:0] act_val);
    assert (act_val === exp_val) else begin
      $display("mismatch %s %s: expected 0x%08h actual 0x%08h",
               cur_test, what, exp_val, act_val);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: pass", cur_test);
    end else begin
      $display("test %s: fail, %0d errors", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  // Drives one instruction at the falling edge and checks reads and write-back
  task automatic step(input logic wr, input logic [REG_AW-1:0] rd_idx, input logic rd_mem,
                      input logic wr_mem, input logic [2:0] f3, input logic m2r,
                      input logic [XLEN-1:0] alu, input logic [XLEN-1:0] sdata,
                      input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2);
    logic [XLEN-1:0] exp_data;
    logic [XLEN-1:0] exp_pc;
    exp_pc     = pc_ctr;
    exp_data   = m2r ? ref_load(alu, f3) : alu; // Memory before this store
    pc         = pc_ctr;
    reg_write  = wr;
    rd         = rd_idx;
    mem_read   = rd_mem;
    mem_write  = wr_mem;
    funct3     = f3;
    mem_to_reg = m2r;
    alu_out    = alu;
    store_data = sdata;
    rs1_addr   = rs1;
    rs2_addr   = rs2;
    pc_ctr     = pc_ctr + 32'd4;
    probe_idx  = probe_idx + 5'd1;
    if (wr_mem) ref_store(alu, f3, sdata);
    #1; // Read ports settle on the bypassed write-back
    check_value("rs1 read", reg_model[rs1], rs1_data);
    check_value("rs2 read", reg_model[rs2], rs2_data);
    @(posedge clk);
    @(negedge clk);
    check_value("wb_reg_write", 32'(wr), 32'(wb_reg_write));
    check_value("wb_rd", 32'(rd_idx), 32'(wb_rd));
    check_value("wb_pc", exp_pc, wb_pc);
    check_value("wb_data", exp_data, wb_data);
    if (wr && rd_idx != '0) begin
      reg_model[rd_idx] = exp_data; // Lands at the next edge
      last_rd           = rd_idx;
    end
  endtask

  task automatic alu_op(input logic [REG_AW-1:0] rd_idx, input logic [XLEN-1:0] value);
    step(1'b1, rd_idx, 1'b0, 1'b0, F3_W, 1'b0, value, '0, last_rd, probe_idx);
  endtask

  task automatic store_op(input logic [2:0] f3, input logic [XLEN-1:0] addr,
                          input logic [XLEN-1:0] data);
    step(1'b0, '0, 1'b0, 1'b1, f3, 1'b0, addr, data, last_rd, probe_idx);
  endtask

  task automatic load_op(input logic [2:0] f3, input logic [REG_AW-1:0] rd_idx,
                         input logic [XLEN-1:0] addr);
    step(1'b1, rd_idx, 1'b1, 1'b0, f3, 1'b1, addr, '0, last_rd, probe_idx);
  endtask

  task automatic idle_op(input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2);
    step(1'b0, '0, 1'b0, 1'b0, F3_W, 1'b0, '0, '0, rs1, rs2);
  endtask

  task automatic wait_reset_release(output logic released);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (rst && cnt < RESET_WAIT_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    released = !rst;
  endtask

  task automatic test_reset();
    begin_test("reset");
    check_value("wb_reg_write", 32'd0, 32'(wb_reg_write));
    check_value("wb_rd", 32'd0, 32'(wb_rd));
    check_value("wb_pc", 32'd0, wb_pc);
    check_value("wb_data", 32'd0, wb_data);
    for (int r = 0; r < 32; r += 5) begin
      @(negedge clk);
      rs1_addr = 5'(r);
      rs2_addr = 5'(31 - r);
      #1;
      check_value("rs1 after reset", 32'd0, rs1_data);
      check_value("rs2 after reset", 32'd0, rs2_data);
    end
    @(negedge clk); // Back on a falling edge
    end_test();
  endtask

  task automatic test_alu_writeback();
    begin_test("alu_writeback");
    alu_op(5'd1, 32'h1234_5678);
    alu_op(5'd2, 32'h8000_0001);
    for (int r = 3; r < 32; r++) begin
      alu_op(5'(r), $random(seed));
    end
    alu_op(5'd0, 32'hffff_ffff); // x0 must stay zero
    idle_op(5'd0, 5'd1);
    idle_op(5'd2, 5'd31);
    end_test();
  endtask

  task automatic test_word_access();
    begin_test("word_access");
    store_op(F3_W, 32'h100, 32'hdead_beef);
    load_op(F3_W, 5'd5, 32'h100);  // Right behind the store
    store_op(F3_W, 32'h104, 32'h0bad_f00d);
    load_op(F3_W, 5'd6, 32'h100);
    load_op(F3_W, 5'd7, 32'h104);
    idle_op(5'd5, 5'd6);
    end_test();
  endtask

  task automatic test_partial_store();
    begin_test("partial_store");
    for (int off = 0; off < 4; off++) begin
      store_op(F3_W, 32'h200, 32'h1122_3344);
      store_op(F3_B, 32'h200 + 32'(off), 32'hffff_ffa0 + 32'(off)); // Upper bits junk
      load_op(F3_W, 5'd8, 32'h200);
      store_op(F3_W, 32'h208, 32'h5566_7788);
      store_op(F3_H, 32'h208 + 32'(off), 32'hcafe_be10 + 32'(off));
      load_op(F3_W, 5'd9, 32'h208);
    end
    end_test();
  endtask

  task automatic test_load_extend();
    logic [XLEN-1:0] base;
    begin_test("load_extend");
    store_op(F3_W, 32'h300, 32'hf28a_c391); // Every byte has its top bit set
    store_op(F3_W, 32'h304, 32'h7e01_6c02); // No top bits set for contrast
    for (int w = 0; w < 2; w++) begin
      base = 32'h300 + 32'(4 * w);
      for (int off = 0; off < 4; off++) begin
        load_op(F3_B, 5'd10, base + 32'(off));
        load_op(F3_BU, 5'd11, base + 32'(off));
        load_op(F3_H, 5'd12, base + 32'(off));
        load_op(F3_HU, 5'd13, base + 32'(off));
      end
    end
    end_test();
  endtask

  task automatic test_random_mix();
    logic [XLEN-1:0]   addr;
    logic [2:0]        f3;
    logic [REG_AW-1:0] rd_idx;
    int unsigned       op;
    begin_test("random_mix");
    for (int n = 0; n < RAND_OPS; n++) begin
      op     = rand_below(3);
      addr   = RAND_BASE + 32'(rand_below(16) * 4) + 32'(rand_below(4));
      rd_idx = 5'(rand_below(32));
      if (op == 0) begin
        case (rand_below(3))
          0:       f3 = F3_B;
          1:       f3 = F3_H;
          default: f3 = F3_W;
        endcase
        step(1'b0, rd_idx, 1'b0, 1'b1, f3, 1'b0, addr, $random(seed),
             5'(rand_below(32)), 5'(rand_below(32)));
      end else if (op == 1) begin
        case (rand_below(5))
          0:       f3 = F3_B;
          1:       f3 = F3_H;
          2:       f3 = F3_W;
          3:       f3 = F3_BU;
          default: f3 = F3_HU;
        endcase
        step(1'b1, rd_idx, 1'b1, 1'b0, f3, 1'b1, addr, '0,
             5'(rand_below(32)), 5'(rand_below(32)));
      end else begin
        // Random ALU result without memory access
        step(1'b1, rd_idx, 1'b0, 1'b0, F3_W, 1'b0, $random(seed), $random(seed),
             5'(rand_below(32)), 5'(rand_below(32)));
      end
    end
    idle_op(last_rd, 5'(rand_below(32)));
    end_test();
  endtask

  // Watchdog for a stuck run
  initial begin
    for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
      @(posedge clk);
    end
    $display("timeout: run exceeded %0d clock cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    seed         = 32'h2ccb_b2e9;
    pc_ctr       = 32'h0000_1000;
    last_rd      = '0;
    probe_idx    = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    pc           = '0;
    reg_write    = 1'b0;
    rd           = '0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    funct3       = '0;
    mem_to_reg   = 1'b0;
    alu_out      = '0;
    store_data   = '0;
    rs1_addr     = '0;
    rs2_addr     = '0;
    for (int i = 0; i < 4*DMEM_DEPTH; i++) ref_mem[i] = 8'h00; // Memory starts cleared
    for (int r = 0; r < 32; r++) reg_model[r] = '0;

    wait_reset_release(reset_seen);
    if (reset_seen) begin
      test_reset();
      test_alu_writeback();
      test_word_access();
      test_partial_store();
      test_load_extend();
      test_random_mix();
    end else begin
      $display("timeout: reset never released after %0d cycles", RESET_WAIT_CYCLES);
    end

    $display("summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, total_errs);
    if (reset_seen && tests_failed == 0 && total_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== mem_wb_stage.f ====
design/riscv_mem_pkg.sv
design/store_align.sv
design/dmem.sv
design/load_extend.sv
design/wback_reg.sv
design/regfile.sv
design/mem_wb_stage.sv
sim/tb_clock.sv
sim/tb_mem_wb_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MEM/WB stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_mem_wb_stage
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" \
  -f mem_wb_stage.f --Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
